/* list.f */
src/cpu_pkg.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_core.sv
sim/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_cpu -o tb_cpu
./obj_dir/tb_cpu | tee sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0

/* sim/tb_cpu.sv */
`default_nettype none

module tb_cpu
  import cpu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 6;

  logic            CLOCK = 1'b0;
  logic            rst_n = 1'b0;
  xlen_t           pc;
  logic [ILEN-1:0] instr;
  xlen_t           mem_addr;
  xlen_t           mem_wdata;
  logic            mem_read;
  logic            mem_write;
  xlen_t           mem_rdata;
  logic            wb_en;
  reg_addr_t       wb_reg;
  xlen_t           wb_data;

  string           names [NUM_TESTS];
  logic [31:0]     progs [NUM_TESTS][16];
  int              lens  [NUM_TESTS];
  int              cur = 0;
  int              errors = 0;
  xlen_t           dmem [64];
  xlen_t           model_regs [32];
  xlen_t           model_mem [64];
  reg_addr_t       exp_wb_reg [$];
  xlen_t           exp_wb_val [$];
  xlen_t           exp_st_addr [$];
  xlen_t           exp_st_data [$];
  xlen_t           exp_ld_addr [$];

  cpu_core UUT (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .pc        (pc),
    .instr     (instr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_rdata (mem_rdata),
    .wb_en     (wb_en),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
  );

  always #2 CLOCK = ~CLOCK;

  // Zero words past the end of the program
  assign instr     = (pc < xlen_t'(4 * lens[cur])) ? progs[cur][pc[5:2]] : '0;
  assign mem_rdata = dmem[mem_addr[8:3]];  // Doubleword index

  always @(posedge CLOCK) begin
    if (rst_n && mem_write) begin
      dmem[mem_addr[8:3]] <= mem_wdata;
    end
  end

  function automatic logic [31:0] r_type(logic [10:0] op, int rd, int rn, int rm);
    return {op, 5'(rm), 6'd0, 5'(rn), 5'(rd)};
  endfunction

  function automatic logic [31:0] d_type(logic [10:0] op, int rt, int rn, int off);
    return {op, 9'(off), 2'b00, 5'(rn), 5'(rt)};
  endfunction

  function automatic int unsigned lcg_next(int unsigned s);
    return (s * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
  endfunction

  function automatic xlen_t xreg(reg_addr_t r);
    return (r == ZERO_REG) ? '0 : model_regs[r];  // xzr reads 0
  endfunction

  task automatic put(input int t, input logic [31:0] w);
    progs[t][lens[t]] = w;
    lens[t]++;
  endtask

  task automatic build_tests();
    int unsigned seed;
    int          r;
    logic [10:0] alu_ops [4];
    alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_ORR};
    for (int t = 0; t < NUM_TESTS; t++) begin
      lens[t] = 0;
      for (int i = 0; i < 16; i++) progs[t][i] = '0;
    end
    names[0] = "alu_independent";
    put(0, r_type(OP_ADD, 10, 1, 2));
    put(0, r_type(OP_SUB, 11, 5, 3));
    put(0, r_type(OP_AND, 12, 6, 7));
    put(0, r_type(OP_ORR, 13, 8, 4));
    names[1] = "alu_forwarding";
    put(1, r_type(OP_ADD, 1, 2, 3));
    put(1, r_type(OP_SUB, 4, 1, 2));   // Distance 1
    put(1, r_type(OP_ORR, 5, 1, 4));   // Distances 2 and 1
    put(1, r_type(OP_AND, 6, 4, 9));
    names[2] = "load_use";
    put(2, d_type(OP_LDUR, 1, 2, 8));
    put(2, r_type(OP_ADD, 3, 1, 4));   // Stalls one cycle
    put(2, d_type(OP_LDUR, 5, 0, 16));
    put(2, r_type(OP_SUB, 6, 7, 5));
    names[3] = "store_load";
    put(3, r_type(OP_ADD, 1, 2, 3));
    put(3, d_type(OP_STUR, 1, 8, -8)); // Forwarded store data
    put(3, d_type(OP_STUR, 4, 16, 24));
    put(3, d_type(OP_LDUR, 5, 0, 0));
    put(3, d_type(OP_LDUR, 6, 16, 24));
    names[4] = "zero_register";
    put(4, r_type(OP_ADD, 31, 1, 2));
    put(4, r_type(OP_ADD, 3, 31, 4));
    put(4, d_type(OP_LDUR, 31, 0, 8));
    put(4, r_type(OP_ORR, 5, 31, 6));
    put(4, r_type(OP_SUB, 7, 8, 31));
    names[5] = "lcg_random";
    seed = 84691;
    for (int i = 0; i < 16; i++) begin
      seed = lcg_next(seed);
      r = int'(seed >> 8);
      case (r % 4)
        0, 1: put(5, r_type(alu_ops[(r >> 17) % 4], (r >> 2) % 8, (r >> 5) % 8, (r >> 8) % 8));
        2: put(5, d_type(OP_LDUR, (r >> 2) % 8, (r >> 5) % 8, ((r >> 11) % 64 - 32) * 8));
        default: put(5, d_type(OP_STUR, (r >> 8) % 8, (r >> 5) % 8, ((r >> 11) % 64 - 32) * 8));
      endcase
    end
  endtask

  // Sequential ISA model, fills the expected event queues
  task automatic run_model(input int t, output int loads);
    logic [31:0] w;
    reg_addr_t   rd;
    xlen_t       a;
    xlen_t       addr;
    xlen_t       res;
    loads = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = xlen_t'(i);
    for (int i = 0; i < 64; i++) model_mem[i] = xlen_t'(5 * i);
    for (int i = 0; i < lens[t]; i++) begin
      w    = progs[t][i];
      rd   = w[4:0];
      a    = xreg(w[9:5]);
      addr = a + xlen_t'($signed(w[20:12]));
      res  = 'x;
      case (w[31:21])
        OP_ADD:  res = a + xreg(w[20:16]);
        OP_SUB:  res = a - xreg(w[20:16]);
        OP_AND:  res = a & xreg(w[20:16]);
        OP_ORR:  res = a | xreg(w[20:16]);
        OP_LDUR: begin
          res = model_mem[addr[8:3]];
          exp_ld_addr.push_back(addr);
          loads++;
        end
        OP_STUR: begin
          model_mem[addr[8:3]] = xreg(rd);
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(xreg(rd));
        end
        default: ;
      endcase
      if (w[31:21] inside {OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_LDUR}) begin
        exp_wb_reg.push_back(rd);
        exp_wb_val.push_back(res);
        if (rd != ZERO_REG) model_regs[rd] = res;
      end
    end
  endtask

  task automatic check_wb(input reg_addr_t got_reg, input xlen_t got_val);
    reg_addr_t want_reg;
    xlen_t     want_val;
    if (exp_wb_reg.size() == 0) begin
      $display("Unexpected writeback to x%0d at %0d ns", got_reg, $time);
      errors++;
      return;
    end
    want_reg = exp_wb_reg.pop_front();
    want_val = exp_wb_val.pop_front();
    if (got_reg !== want_reg) begin
      $display("CHECK FAILED at %0d ns: wb_reg expected %0d got %0d", $time, want_reg, got_reg);
      errors++;
    end
    if (got_val !== want_val) begin
      $display("CHECK FAILED at %0d ns: wb_data expected %h got %h", $time, want_val, got_val);
      errors++;
    end
  endtask

  task automatic check_store(input xlen_t got_addr, input xlen_t got_data);
    xlen_t want_addr;
    xlen_t want_data;
    if (exp_st_addr.size() == 0) begin
      $display("Unexpected store to address %h at %0d ns", got_addr, $time);
      errors++;
      return;
    end
    want_addr = exp_st_addr.pop_front();
    want_data = exp_st_data.pop_front();
    if (got_addr !== want_addr) begin
      $display("CHECK FAILED at %0d ns: mem_addr expected %h got %h", $time, want_addr, got_addr);
      errors++;
    end
    if (got_data !== want_data) begin
      $display("CHECK FAILED at %0d ns: mem_wdata expected %h got %h", $time, want_data, got_data);
      errors++;
    end
  endtask

  task automatic check_load(input xlen_t got_addr);
    xlen_t want_addr;
    if (exp_ld_addr.size() == 0) begin
      $display("Unexpected load from address %h at %0d ns", got_addr, $time);
      errors++;
      return;
    end
    want_addr = exp_ld_addr.pop_front();
    if (got_addr !== want_addr) begin
      $display("CHECK FAILED at %0d ns: mem_addr expected %h got %h", $time, want_addr, got_addr);
      errors++;
    end
  endtask

  task automatic sample_outputs();
    if (wb_en) check_wb(wb_reg, wb_data);
    if (mem_write) check_store(mem_addr, mem_wdata);
    if (mem_read) check_load(mem_addr);
  endtask

  initial begin
    int loads;
    int err0;
    build_tests();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_model(t, loads);
      @(negedge CLOCK);
      rst_n = 1'b0;
      cur   = t;
      for (int i = 0; i < 64; i++) dmem[i] = xlen_t'(5 * i);
      repeat (3) @(negedge CLOCK);
      rst_n = 1'b1;
      err0  = errors;
      // Each load adds at most one bubble
      repeat (lens[t] + loads + 8) begin
        @(negedge CLOCK);
        sample_outputs();
      end
      if (exp_wb_reg.size() != 0) begin
        $display("%0d expected writebacks never appeared", exp_wb_reg.size());
        errors++;
      end
      if (exp_st_addr.size() != 0) begin
        $display("%0d expected stores never appeared", exp_st_addr.size());
        errors++;
      end
      if (exp_ld_addr.size() != 0) begin
        $display("%0d expected loads never appeared", exp_ld_addr.size());
        errors++;
      end
      exp_wb_reg.delete();
      exp_wb_val.delete();
      exp_st_addr.delete();
      exp_st_data.delete();
      exp_ld_addr.delete();
      $display("%s: %0d errors", names[t], errors - err0);
    end
    $display("Ran %0d programs, %0d errors", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog, twice the expected run time
  initial begin
    int limit;
    #1;
    limit = 0;
    for (int t = 0; t < NUM_TESTS; t++) limit += (lens[t] + 11) * 4 * 2;
    #(limit);
    $display("Simulation still running after %0d ns, stopped by the watchdog", limit);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* src/cpu_core.sv */
`default_nettype none

module cpu_core
  import cpu_pkg::*;
(
  input  logic            CLOCK,
  input  logic            rst_n,
  output xlen_t           pc,
  input  logic [ILEN-1:0] instr,
  output xlen_t           mem_addr,
  output xlen_t           mem_wdata,
  output logic            mem_read,
  output logic            mem_write,
  input  xlen_t           mem_rdata,
  output logic            wb_en,
  output reg_addr_t       wb_reg,
  output xlen_t           wb_data
);

  logic    stall;
  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  fetch_stage u_fetch (
    .CLOCK (CLOCK),
    .rst_n (rst_n),
    .stall (stall),
    .instr (instr),
    .pc    (pc),
    .if_id (if_id)
  );

  decode_stage u_decode (
    .CLOCK   (CLOCK),
    .rst_n   (rst_n),
    .if_id   (if_id),
    .wb_en   (wb_en),
    .wb_reg  (wb_reg),
    .wb_data (wb_data),
    .stall   (stall),
    .id_ex   (id_ex)
  );

  execute_stage u_execute (
    .CLOCK   (CLOCK),
    .rst_n   (rst_n),
    .id_ex   (id_ex),
    .mem_wb  (mem_wb),
    .wb_data (wb_data),
    .ex_mem  (ex_mem)
  );

  memory_stage u_memory (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .ex_mem    (ex_mem),
    .mem_rdata (mem_rdata),
    .mem_wb    (mem_wb),
    .wb_en     (wb_en),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
  );

  // Data memory port straight from EX/MEM
  assign mem_addr  = ex_mem.result;
  assign mem_wdata = ex_mem.store_data;
  assign mem_read  = ex_mem.ctrl.mem_read;
  assign mem_write = ex_mem.ctrl.mem_write;

endmodule

`default_nettype wire

/* src/memory_stage.sv */
`default_nettype none

module memory_stage
  import cpu_pkg::*;
(
  input  logic      CLOCK,
  input  logic      rst_n,
  input  ex_mem_t   ex_mem,
  input  xlen_t     mem_rdata,
  output mem_wb_t   mem_wb,
  output logic      wb_en,
  output reg_addr_t wb_reg,
  output xlen_t     wb_data
);

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
      mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
      mem_wb.result     <= ex_mem.result;
      mem_wb.load_data  <= mem_rdata;  // Read data is combinational
      mem_wb.rd         <= ex_mem.rd;
    end
  end

  // Writeback select
  assign wb_en   = mem_wb.reg_write;
  assign wb_reg  = mem_wb.rd;
  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`default_nettype none

module execute_stage
  import cpu_pkg::*;
(
  input  logic    CLOCK,
  input  logic    rst_n,
  input  id_ex_t  id_ex,
  input  mem_wb_t mem_wb,
  input  xlen_t   wb_data,
  output ex_mem_t ex_mem
);

  xlen_t op_a;
  xlen_t fwd_b;
  xlen_t op_b;
  xlen_t result;

  // Nearest producer wins
  function automatic xlen_t forward(input reg_addr_t src, input xlen_t reg_val);
    if (ex_mem.ctrl.reg_write && (ex_mem.rd != ZERO_REG) && (ex_mem.rd == src)) begin
      return ex_mem.result;
    end else if (mem_wb.reg_write && (mem_wb.rd != ZERO_REG) && (mem_wb.rd == src)) begin
      return wb_data;
    end
    return reg_val;
  endfunction

  assign op_a  = forward(id_ex.rn, id_ex.rn_data);
  assign fwd_b = forward(id_ex.rm, id_ex.rm_data);
  assign op_b  = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

  always_comb begin
    unique case (id_ex.ctrl.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_ORR: result = op_a | op_b;
      default: result = op_a + op_b;
    endcase
  end

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.result     <= result;  // Address for loads and stores
      ex_mem.store_data <= fwd_b;
      ex_mem.rd         <= id_ex.rd;
    end
  end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage
  import cpu_pkg::*;
(
  input  logic      CLOCK,
  input  logic      rst_n,
  input  if_id_t    if_id,
  input  logic      wb_en,
  input  reg_addr_t wb_reg,
  input  xlen_t     wb_data,
  output logic      stall,
  output id_ex_t    id_ex
);

  instr_u    instr;
  ctrl_t     ctrl;
  reg_addr_t src_b;
  xlen_t     imm;
  xlen_t     rn_data;
  xlen_t     rm_data;

  assign instr = if_id.instr;

  always_comb begin
    ctrl = '0;  // Unknown opcode stays a bubble
    unique case (instr.r.opcode)
      OP_ADD: begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.reg_write = 1'b1;
      end
      OP_SUB: begin
        ctrl.alu_op    = ALU_SUB;
        ctrl.reg_write = 1'b1;
      end
      OP_AND: begin
        ctrl.alu_op    = ALU_AND;
        ctrl.reg_write = 1'b1;
      end
      OP_ORR: begin
        ctrl.alu_op    = ALU_ORR;
        ctrl.reg_write = 1'b1;
      end
      OP_LDUR: begin
        ctrl.alu_src    = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      OP_STUR: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      default: ;
    endcase
  end

  // D-format reads rt as second source
  assign src_b = (ctrl.mem_read || ctrl.mem_write) ? instr.d.rt : instr.r.rm;
  assign imm   = {{(XLEN-9){instr.d.addr[8]}}, instr.d.addr};

  // Load in EX feeding this instruction
  assign stall = id_ex.ctrl.mem_read &&
                 ((id_ex.rd == instr.r.rn) || (id_ex.rd == src_b));

  register_file u_regs (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .rd_addr_a (instr.r.rn),
    .rd_addr_b (src_b),
    .rd_data_a (rn_data),
    .rd_data_b (rm_data),
    .wr_en     (wb_en),
    .wr_addr   (wb_reg),
    .wr_data   (wb_data)
  );

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else begin
      id_ex.ctrl    <= stall ? ctrl_t'('0) : ctrl;  // Bubble during load-use
      id_ex.rn_data <= rn_data;
      id_ex.rm_data <= rm_data;
      id_ex.imm     <= imm;
      id_ex.rd      <= instr.r.rd;  // Same bits as rt
      id_ex.rn      <= instr.r.rn;
      id_ex.rm      <= src_b;
    end
  end

endmodule

`default_nettype wire

/* src/register_file.sv */
`default_nettype none

module register_file
  import cpu_pkg::*;
(
  input  logic      CLOCK,
  input  logic      rst_n,
  input  reg_addr_t rd_addr_a,
  input  reg_addr_t rd_addr_b,
  output xlen_t     rd_data_a,
  output xlen_t     rd_data_b,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  xlen_t     wr_data
);

  xlen_t regs [32];

  // Zero register first, then bypass of this cycle's write
  function automatic xlen_t read_port(input reg_addr_t addr);
    if (addr == ZERO_REG) begin
      return '0;
    end else if (wr_en && (wr_addr == addr)) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= xlen_t'(i);  // xi holds i
      end
    end else if (wr_en && (wr_addr != ZERO_REG)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data_a = read_port(rd_addr_a);
  assign rd_data_b = read_port(rd_addr_b);

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
`default_nettype none

module fetch_stage
  import cpu_pkg::*;
(
  input  logic   CLOCK,
  input  logic   rst_n,
  input  logic   stall,
  input  instr_u instr,
  output xlen_t  pc,
  output if_id_t if_id
);

  // Sequential fetch only, no redirect
  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc + PC_STEP;
    end
  end

  // Zero word after reset decodes as a bubble
  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      if_id <= '0;
    end else if (!stall) begin
      if_id.pc    <= pc;
      if_id.instr <= instr;
    end
  end

endmodule

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  localparam reg_addr_t ZERO_REG = 5'd31;  // xzr
  localparam xlen_t     PC_STEP  = 64'd4;

  // Opcode field, bits 31:21
  localparam logic [10:0] OP_ADD  = 11'b10001011000;
  localparam logic [10:0] OP_SUB  = 11'b11001011000;
  localparam logic [10:0] OP_AND  = 11'b10001010000;
  localparam logic [10:0] OP_ORR  = 11'b10101010000;
  localparam logic [10:0] OP_LDUR = 11'b11111000010;
  localparam logic [10:0] OP_STUR = 11'b11111000000;

  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,  // Also address generation
    ALU_SUB = 2'b01,
    ALU_AND = 2'b10,
    ALU_ORR = 2'b11
  } alu_op_e;

  typedef struct packed {
    logic [10:0] opcode;
    reg_addr_t   rm;
    logic [5:0]  shamt;
    reg_addr_t   rn;
    reg_addr_t   rd;
  } r_fmt_t;

  typedef struct packed {
    logic [10:0] opcode;
    logic [8:0]  addr;    // Signed byte offset
    logic [1:0]  op2;
    reg_addr_t   rn;
    reg_addr_t   rt;
  } d_fmt_t;

  typedef union packed {
    r_fmt_t r;
    d_fmt_t d;
  } instr_u;

  // All zero is a bubble
  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;     // Second operand from immediate
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
  } ctrl_t;

  typedef struct packed {
    xlen_t  pc;
    instr_u instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    xlen_t     rn_data;
    xlen_t     rm_data;
    xlen_t     imm;
    reg_addr_t rd;
    reg_addr_t rn;
    reg_addr_t rm;        // rm or rt, whichever is read
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    xlen_t     result;
    xlen_t     store_data;
    reg_addr_t rd;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    xlen_t     result;
    xlen_t     load_data;
    reg_addr_t rd;
  } mem_wb_t;

endpackage

`default_nettype wire
